/* Bender.yml */
package:
  name: ipsum

sources:
  - rtl/ipsum_pkg.sv
  - rtl/ipsum_fifo_ctrl.sv
  - rtl/ipsum_fifo.sv
  - rtl/glb_bank.sv
  - rtl/ipsum_apb_regs.sv
  - rtl/ipsum_top.sv
  - target: simulation
    files:
      - sim/ipsum_checker.sv
      - sim/tb_ipsum.sv

/* rtl/glb_bank.sv */
`timescale 1ns/1ps

module glb_bank #(
    parameter int GLB_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ipsum_pkg::glb_wr_t   wr_i,
    input  logic                 rd_req_i,
    input  ipsum_pkg::glb_addr_t rd_addr_i,
    output logic                 permit_o,
    output ipsum_pkg::word_t     rd_data_o
);

    localparam int IDX_W = (GLB_WORDS > 1) ? $clog2(GLB_WORDS) : 1;

    ipsum_pkg::word_t mem [GLB_WORDS];
    logic [13:0]      wr_word, rd_word;  // byte address / 4
    logic [IDX_W-1:0] wr_idx, rd_idx;

    assign wr_word = wr_i.addr[15:2];
    assign rd_word = rd_addr_i[15:2];
    assign wr_idx  = wr_word[IDX_W-1:0];
    assign rd_idx  = rd_word[IDX_W-1:0];

    // apb write owns the port, the reader waits
    assign permit_o = rd_req_i && !wr_i.en;

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_idx] <= wr_i.data;
        end else if (permit_o) begin
            rd_data_o <= mem[rd_idx];  // valid one cycle after permit
        end
    end

    // upper address bits are dropped by the index, so catch aliasing here
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_i.en |-> (int'(wr_word) < GLB_WORDS));

    a_rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        permit_o |-> (int'(rd_word) < GLB_WORDS));

endmodule

/* rtl/ipsum_apb_regs.sv */
`timescale 1ns/1ps

module ipsum_apb_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ipsum_pkg::apb_req_t   apb_req_i,
    input  logic                  done_i,
    input  logic                  fifo_empty_i,
    output ipsum_pkg::apb_rsp_t   apb_rsp_o,
    output ipsum_pkg::ipsum_job_t job_o,
    output logic                  start_o,
    output logic                  flush_o,
    output ipsum_pkg::glb_wr_t    glb_wr_o
);

    logic                 access;
    logic                 wr_en;
    logic                 in_window;
    logic [11:0]          win_off;
    ipsum_pkg::glb_addr_t base_q;
    ipsum_pkg::pop_cnt_t  pop_num_q;
    ipsum_pkg::word_t     rdata;

    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign wr_en     = access && apb_req_i.pwrite;
    assign in_window = (apb_req_i.paddr >= ipsum_pkg::GLB_WIN_BASE);
    assign win_off   = apb_req_i.paddr - ipsum_pkg::GLB_WIN_BASE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q    <= '0;
            pop_num_q <= '0;
        end else if (wr_en) begin
            if (apb_req_i.paddr == ipsum_pkg::REG_BASE) begin
                base_q <= apb_req_i.pwdata[15:0];
            end
            if (apb_req_i.paddr == ipsum_pkg::REG_POPNUM) begin
                pop_num_q <= apb_req_i.pwdata[15:0];
            end
        end
    end

    // ctrl bits are self clearing, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_o <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            start_o <= wr_en && (apb_req_i.paddr == ipsum_pkg::REG_CTRL)
                       && apb_req_i.pwdata[0];
            flush_o <= wr_en && (apb_req_i.paddr == ipsum_pkg::REG_CTRL)
                       && apb_req_i.pwdata[1];
        end
    end

    assign job_o.base    = base_q;
    assign job_o.pop_num = pop_num_q;

    // window write goes straight to the bank in the access cycle
    assign glb_wr_o.en   = wr_en && in_window;
    assign glb_wr_o.addr = {4'd0, win_off};
    assign glb_wr_o.data = apb_req_i.pwdata;

    always_comb begin
        rdata = '0;
        unique case (apb_req_i.paddr)
            ipsum_pkg::REG_BASE:   rdata = {16'd0, base_q};
            ipsum_pkg::REG_POPNUM: rdata = {16'd0, pop_num_q};
            ipsum_pkg::REG_STATUS: rdata = {30'd0, fifo_empty_i, done_i};
            default:               rdata = '0;  // ctrl and window read as zero
        endcase
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;  // no wait states
    assign apb_rsp_o.pslverr = 1'b0;

endmodule

/* rtl/ipsum_fifo.sv */
`timescale 1ns/1ps

module ipsum_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush_i,
    input  logic                            push_i,
    input  ipsum_pkg::psum_t                push_data_i,
    input  logic                            pop_i,
    output ipsum_pkg::psum_t                rd_data_o,
    output logic                            rd_valid_o,
    output logic                            full_o,
    output logic                            empty_o,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    ipsum_pkg::psum_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push, do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush_i) begin
            mem[wr_ptr] <= push_data_i;
        end
        if (do_pop) begin
            rd_data_o <= mem[rd_ptr];  // registered read
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= do_pop && !flush_i;
        end
    end

    assign count_o = count;
    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

/* rtl/ipsum_fifo_ctrl.sv */
`timescale 1ns/1ps

module ipsum_fifo_ctrl #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic                           flush_i,
    input  ipsum_pkg::ipsum_job_t          job_i,
    input  logic                           permit_i,
    input  logic                           fifo_full_i,
    input  logic                           fifo_empty_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
    input  ipsum_pkg::word_t               rd_data_i,
    output logic                           read_req_o,
    output ipsum_pkg::glb_addr_t           rd_addr_o,
    output logic                           push_o,
    output ipsum_pkg::psum_t               push_data_o,
    output logic                           pop_o,
    output logic                           fifo_flush_o,
    output logic                           done_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ipsum_pkg::ctrl_state_t cs, ns;
    ipsum_pkg::ipsum_job_t  job_q;
    ipsum_pkg::glb_addr_t   read_ptr;
    ipsum_pkg::pop_cnt_t    pop_cnt;
    logic [CNT_W-1:0]       inflight;    // permitted reads whose push is still pending
    logic [CNT_W:0]         fill_sum;
    logic                   half_sel_q;  // address bit 1 of the read being returned
    logic                   last_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs <= ipsum_pkg::IDLE;
        end else begin
            cs <= ns;
        end
    end

    assign last_pop = pop_o && (pop_cnt == job_q.pop_num - 16'd1);

    always_comb begin
        ns = cs;
        unique case (cs)
            ipsum_pkg::IDLE: begin
                // a zero-length job has nothing to do
                if (start_i && job_i.pop_num != '0) begin
                    ns = fifo_empty_i ? ipsum_pkg::PUSH : ipsum_pkg::POP;
                end
            end
            ipsum_pkg::POP: begin
                if (last_pop) begin
                    ns = ipsum_pkg::IDLE;
                end else if (fifo_empty_i) begin
                    ns = ipsum_pkg::PUSH;
                end
            end
            ipsum_pkg::PUSH: begin
                if (fifo_full_i) begin
                    ns = ipsum_pkg::POP;
                end
            end
            default: ns = ipsum_pkg::IDLE;
        endcase
    end

    // job is sampled every idle cycle, frozen once running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_q <= '0;
        end else if (cs == ipsum_pkg::IDLE) begin
            job_q <= job_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt <= '0;
        end else if (cs == ipsum_pkg::IDLE) begin
            pop_cnt <= '0;
        end else if (pop_o) begin
            pop_cnt <= pop_cnt + 16'd1;
        end
    end

    assign fifo_flush_o = flush_i && (cs == ipsum_pkg::IDLE);

    // half-word pointer, survives job boundaries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_ptr <= '0;
        end else if (fifo_flush_o) begin
            read_ptr <= '0;
        end else if (permit_i) begin
            read_ptr <= read_ptr + 16'd2;
        end
    end

    assign rd_addr_o = job_q.base + read_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight <= '0;
        end else begin
            inflight <= inflight + CNT_W'(permit_i) - CNT_W'(push_o);
        end
    end

    assign fill_sum   = fifo_count_i + inflight;
    assign read_req_o = (cs == ipsum_pkg::PUSH) && (fill_sum < FIFO_DEPTH);

    // push lines up with the glb read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_o     <= 1'b0;
            half_sel_q <= 1'b0;
        end else begin
            push_o <= permit_i;
            if (permit_i) begin
                half_sel_q <= rd_addr_o[1];
            end
        end
    end

    assign push_data_o = half_sel_q ? {16'd0, rd_data_i[31:16]} : {16'd0, rd_data_i[15:0]};

    assign pop_o  = (cs == ipsum_pkg::POP) && !fifo_empty_i;
    assign done_o = (cs == ipsum_pkg::IDLE);

    // request throttling must keep the fifo from overflowing
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_o |-> !fifo_full_i);

    a_inflight_fits: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(inflight) + int'(fifo_count_i)) <= FIFO_DEPTH);

endmodule

/* rtl/ipsum_pkg.sv */
package ipsum_pkg;

    typedef logic [31:0] word_t;      // one GLB word, also the APB data width
    typedef logic [31:0] psum_t;      // fifo entry, zero-extended half-word
    typedef logic [15:0] glb_addr_t;  // byte address into the GLB
    typedef logic [15:0] pop_cnt_t;   // pops requested per job

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        word_t       pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        glb_addr_t base;     // byte address of half-word zero
        pop_cnt_t  pop_num;
    } ipsum_job_t;

    typedef struct packed {
        logic      en;
        glb_addr_t addr;     // byte address, word aligned
        word_t     data;
    } glb_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        POP,
        PUSH
    } ctrl_state_t;

    // apb register map
    localparam logic [11:0] REG_CTRL     = 12'h000;
    localparam logic [11:0] REG_BASE     = 12'h004;
    localparam logic [11:0] REG_POPNUM   = 12'h008;
    localparam logic [11:0] REG_STATUS   = 12'h00C;
    localparam logic [11:0] GLB_WIN_BASE = 12'h400;

endpackage

/* rtl/ipsum_top.sv */
`timescale 1ns/1ps

module ipsum_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int GLB_WORDS  = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  ipsum_pkg::apb_req_t apb_req_i,
    output ipsum_pkg::apb_rsp_t apb_rsp_o,
    output logic                ipsum_valid_o,
    output ipsum_pkg::psum_t    ipsum_data_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ipsum_pkg::ipsum_job_t job;
    ipsum_pkg::glb_wr_t    glb_wr;
    ipsum_pkg::glb_addr_t  rd_addr;
    ipsum_pkg::word_t      glb_rd_data;
    ipsum_pkg::psum_t      push_data;
    logic                  start, flush, fifo_flush;
    logic                  read_req, permit;
    logic                  push, pop, done;
    logic                  fifo_full, fifo_empty;
    logic [CNT_W-1:0]      fifo_count;

    ipsum_apb_regs i_apb_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req_i    (apb_req_i),
        .done_i       (done),
        .fifo_empty_i (fifo_empty),
        .apb_rsp_o    (apb_rsp_o),
        .job_o        (job),
        .start_o      (start),
        .flush_o      (flush),
        .glb_wr_o     (glb_wr)
    );

    ipsum_fifo_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .flush_i      (flush),
        .job_i        (job),
        .permit_i     (permit),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .fifo_count_i (fifo_count),
        .rd_data_i    (glb_rd_data),
        .read_req_o   (read_req),
        .rd_addr_o    (rd_addr),
        .push_o       (push),
        .push_data_o  (push_data),
        .pop_o        (pop),
        .fifo_flush_o (fifo_flush),
        .done_o       (done)
    );

    ipsum_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (fifo_flush),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .rd_data_o   (ipsum_data_o),
        .rd_valid_o  (ipsum_valid_o),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .count_o     (fifo_count)
    );

    glb_bank #(.GLB_WORDS(GLB_WORDS)) i_glb (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (glb_wr),
        .rd_req_i  (read_req),
        .rd_addr_i (rd_addr),
        .permit_o  (permit),
        .rd_data_o (glb_rd_data)
    );

endmodule

/* sim/ipsum_checker.sv */
`timescale 1ns/1ps

module ipsum_checker #(
    parameter int GLB_WORDS = 256
) (
    input logic             clk,
    input logic             rst_n,
    input logic             ipsum_valid_i,
    input ipsum_pkg::psum_t ipsum_data_i
);

    ipsum_pkg::word_t     gimg [GLB_WORDS];  // image of every word written through the window
    ipsum_pkg::glb_addr_t base_q         = '0;
    int                   hw_idx         = 0;  // half-words popped since the last flush
    int                   pops_seen      = 0;
    int                   pops_expected  = 0;
    int                   test_err_start = 0;
    int                   err_count      = 0;
    int                   tests_run      = 0;
    int                   tests_failed   = 0;

    // half-word k: low half of word k/2 for even k, high half for odd k
    function automatic ipsum_pkg::psum_t predict(input int idx);
        int               word_idx;
        ipsum_pkg::word_t w;
        word_idx = int'(base_q) / 4 + idx / 2;
        if (word_idx >= GLB_WORDS) begin
            return 'x;
        end
        w = gimg[word_idx];
        return (idx % 2 == 0) ? {16'd0, w[15:0]} : {16'd0, w[31:16]};
    endfunction

    always @(negedge clk) begin
        if (!rst_n) begin
            hw_idx = 0;  // read pointer restarts at zero
        end else if (ipsum_valid_i) begin
            if (ipsum_data_i !== predict(hw_idx)) begin
                $display("mismatch ipsum_data_o: half-word %0d expected %h got %h",
                         hw_idx, predict(hw_idx), ipsum_data_i);
                err_count++;
            end
            hw_idx++;
            pops_seen++;
        end
    end

    task automatic note_glb_write(input int idx, input ipsum_pkg::word_t data);
        gimg[idx] = data;
    endtask

    // flush plus new base, sequence starts over
    task automatic rebase(input ipsum_pkg::glb_addr_t base);
        base_q = base;
        hw_idx = 0;
    endtask

    task automatic add_expected(input int n);
        pops_expected += n;
    endtask

    task automatic begin_test();
        pops_seen      = 0;
        pops_expected  = 0;
        test_err_start = err_count;
    endtask

    task automatic compare_status(input ipsum_pkg::word_t got, input ipsum_pkg::word_t exp,
                                  input ipsum_pkg::word_t mask);
        if ((got & mask) !== exp) begin
            $display("mismatch prdata (STATUS): expected %h got %h, mask %h",
                     exp, got & mask, mask);
            err_count++;
        end
    endtask

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic end_test(input string name);
        if (pops_seen != pops_expected) begin
            $display("%s: %0d values were popped but %0d were expected",
                     name, pops_seen, pops_expected);
            err_count++;
        end
        tests_run++;
        if (err_count != test_err_start) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, err_count - test_err_start);
        end else begin
            $display("test %s: passed, %0d values popped", name, pops_seen);
        end
    endtask

endmodule

/* sim/tb_ipsum.sv */
`timescale 1ns/1ps

module tb_ipsum;

    localparam int FIFO_DEPTH = 8;
    localparam int GLB_WORDS  = 256;
    // largest pop count each test can draw, summed
    localparam int MAX_POPS = (FIFO_DEPTH - 1) + (5 * FIFO_DEPTH - 1) + 24 + 20
                              + (4 * FIFO_DEPTH - 1);
    localparam int WATCHDOG_CYCLES = MAX_POPS * 4 * FIFO_DEPTH + 3000;

    logic                clk;
    logic                rst_n;
    ipsum_pkg::apb_req_t apb_req;
    ipsum_pkg::apb_rsp_t apb_rsp;
    logic                ipsum_valid;
    ipsum_pkg::psum_t    ipsum_data;
    logic [31:0]         rng_state = 32'h3f5b201a;

    ipsum_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .GLB_WORDS  (GLB_WORDS)
    ) i_ipsum_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .apb_req_i     (apb_req),
        .apb_rsp_o     (apb_rsp),
        .ipsum_valid_o (ipsum_valid),
        .ipsum_data_o  (ipsum_data)
    );

    ipsum_checker #(.GLB_WORDS(GLB_WORDS)) i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .ipsum_valid_i (ipsum_valid),
        .ipsum_data_i  (ipsum_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((next_rand() >> 8) % (hi - lo + 1));  // low lcg bits are weak
    endfunction

    // zero wait states and no slave errors in any access phase
    task automatic check_apb_rsp();
        if (apb_rsp.pready !== 1'b1) begin
            i_checker.flag_error($sformatf("mismatch pready: expected 1 got %h",
                                           apb_rsp.pready));
        end
        if (apb_rsp.pslverr !== 1'b0) begin
            i_checker.flag_error($sformatf("mismatch pslverr: expected 0 got %h",
                                           apb_rsp.pslverr));
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input ipsum_pkg::word_t data);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;  // access, completes at the next rising edge
        check_apb_rsp();
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output ipsum_pkg::word_t data);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        data = apb_rsp.prdata;  // held until the access edge
        check_apb_rsp();
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic glb_write(input int idx, input ipsum_pkg::word_t data);
        apb_write(ipsum_pkg::GLB_WIN_BASE + 12'(idx * 4), data);
        i_checker.note_glb_write(idx, data);
    endtask

    task automatic check_status(input logic [1:0] exp, input logic [1:0] mask);
        ipsum_pkg::word_t st;
        apb_read(ipsum_pkg::REG_STATUS, st);
        i_checker.compare_status(st, {30'd0, exp}, {30'd0, mask});
    endtask

    task automatic start_job(input int pops);
        i_checker.add_expected(pops);
        apb_write(ipsum_pkg::REG_POPNUM, 32'(pops));
        apb_write(ipsum_pkg::REG_CTRL, 32'h1);
    endtask

    // polls STATUS until done, optionally mixing in window writes
    task automatic wait_done(input int pops, input bit with_traffic);
        ipsum_pkg::word_t st;
        logic [31:0]      r;
        int               polls;
        st    = '0;
        polls = 0;
        while (st[0] !== 1'b1 && polls < pops * FIFO_DEPTH + 16) begin
            r = next_rand();
            if (with_traffic && r[12]) begin
                glb_write(192 + int'(r[21:16]), next_rand());  // region no job reads
            end else begin
                apb_read(ipsum_pkg::REG_STATUS, st);
                polls++;
            end
        end
        if (st[0] !== 1'b1) begin
            i_checker.flag_error("timed out waiting for done to rise again");
        end
        repeat (4) @(negedge clk);  // last popped value reaches the checker
    endtask

    initial begin
        int p;
        int q;
        rst_n   = 1'b0;
        apb_req = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        i_checker.begin_test();
        check_status(2'b11, 2'b11);
        repeat (10) @(negedge clk);
        i_checker.end_test("reset state");

        i_checker.begin_test();
        for (int i = 0; i < 128; i++) begin
            glb_write(i, next_rand());
        end
        p = rand_range(1, FIFO_DEPTH - 1);
        start_job(p);
        check_status(2'b00, 2'b01);
        wait_done(p, 1'b0);
        check_status(2'b01, 2'b01);
        i_checker.end_test("single job");

        i_checker.begin_test();
        p = rand_range(4 * FIFO_DEPTH, 5 * FIFO_DEPTH - 1);  // several refills
        start_job(p);
        wait_done(p, 1'b0);
        i_checker.end_test("long job");

        // prefetched entries carry over into the second job
        i_checker.begin_test();
        p = rand_range(1, 12);
        start_job(p);
        wait_done(p, 1'b0);
        q = rand_range(1, 12);
        start_job(q);
        wait_done(q, 1'b0);
        i_checker.end_test("back to back jobs");

        i_checker.begin_test();
        apb_write(ipsum_pkg::REG_CTRL, 32'h2);
        apb_write(ipsum_pkg::REG_BASE, 32'h100);
        i_checker.rebase(16'h100);
        check_status(2'b11, 2'b11);
        p = rand_range(10, 20);
        start_job(p);
        wait_done(p, 1'b0);
        i_checker.end_test("flush and rebase");

        i_checker.begin_test();
        p = rand_range(3 * FIFO_DEPTH, 4 * FIFO_DEPTH - 1);
        start_job(p);
        check_status(2'b00, 2'b01);
        apb_write(ipsum_pkg::REG_CTRL, 32'h1);  // busy, must be ignored
        wait_done(p, 1'b1);
        repeat (20) @(negedge clk);
        check_status(2'b01, 2'b01);
        i_checker.end_test("contention");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 i_checker.tests_run, i_checker.tests_failed, i_checker.err_count);
        if (i_checker.err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/ipsum_pkg.sv
rtl/ipsum_fifo_ctrl.sv
rtl/ipsum_fifo.sv
rtl/glb_bank.sv
rtl/ipsum_apb_regs.sv
rtl/ipsum_top.sv
sim/ipsum_checker.sv
sim/tb_ipsum.sv
